/* files.f */
source/soc_pkg.sv
source/axil_iob_bridge.sv
source/iob_split.sv
source/iob_sram.sv
source/soc_boot_ctrl.sv
source/soc_fabric_top.sv
sim/tb_soc_fabric_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_soc_fabric_top \
   -Mdir obj_dir -o sim_fabric > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/sim_fabric > sim.log 2>&1 \
   || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log

grep -qF "** FAIL **" sim.log && { echo "test failed"; exit 1; }
grep -qF "** PASS **" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "test passed"

/* sim/tb_soc_fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric_top
   import soc_pkg::*;
();

   localparam int CLK_PERIOD  = 40;
   localparam int SRAM_ADDR_W = 8;
   localparam int RST_CYCLES  = 4;

   localparam logic [1:0] OP_WR    = 2'd0;
   localparam logic [1:0] OP_RD    = 2'd1;
   localparam logic [1:0] OP_PULSE = 2'd2;

   typedef struct packed {
      logic [1:0]          op;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
      logic [DATA_W-1:0]   exp;
   } step_t;

   localparam int N_STEPS     = 24;
   localparam int CYCLE_LIMIT = 30 * N_STEPS + 200;

   // the model supplies the expected data of SRAM reads
   localparam step_t STEPS [N_STEPS] = '{
      '{OP_RD,    12'h804, 32'h0000_0000, 4'h0, 32'h0000_0001},
      '{OP_RD,    12'h800, 32'h0000_0000, 4'h0, 32'h0000_0001},
      '{OP_WR,    12'h000, 32'hdead_beef, 4'hf, 32'h0000_0000},
      '{OP_WR,    12'h004, 32'h1234_5678, 4'hf, 32'h0000_0000},
      '{OP_WR,    12'h3fc, 32'ha5a5_a5a5, 4'hf, 32'h0000_0000},
      '{OP_RD,    12'h000, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h004, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_WR,    12'h000, 32'h0000_aa55, 4'h3, 32'h0000_0000},
      '{OP_WR,    12'h004, 32'hcc00_0000, 4'h8, 32'h0000_0000},
      '{OP_WR,    12'h3fc, 32'h0099_0000, 4'h4, 32'h0000_0000},
      '{OP_RD,    12'h000, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h004, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h3fc, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_WR,    12'h800, 32'h0000_0003, 4'h1, 32'h0000_0000},
      '{OP_PULSE, 12'h000, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h804, 32'h0000_0000, 4'h0, 32'h0000_0101},
      '{OP_WR,    12'h800, 32'h0000_0002, 4'h1, 32'h0000_0000},
      '{OP_RD,    12'h800, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_PULSE, 12'h000, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h804, 32'h0000_0000, 4'h0, 32'h0000_0200},
      '{OP_WR,    12'h800, 32'h5a5a_5a51, 4'hf, 32'h0000_0000},
      '{OP_RD,    12'h000, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h808, 32'h0000_0000, 4'h0, 32'h0000_0000},
      '{OP_RD,    12'h804, 32'h0000_0000, 4'h0, 32'h0000_0201}
   };

   logic                clk_i;
   logic                arst_n_i;
   logic [ADDR_W-1:0]   s_axil_awaddr_i;
   logic                s_axil_awvalid_i;
   logic                s_axil_awready_o;
   logic [DATA_W-1:0]   s_axil_wdata_i;
   logic [DATA_W/8-1:0] s_axil_wstrb_i;
   logic                s_axil_wvalid_i;
   logic                s_axil_wready_o;
   logic [1:0]          s_axil_bresp_o;
   logic                s_axil_bvalid_o;
   logic                s_axil_bready_i;
   logic [ADDR_W-1:0]   s_axil_araddr_i;
   logic                s_axil_arvalid_i;
   logic                s_axil_arready_o;
   logic [DATA_W-1:0]   s_axil_rdata_o;
   logic [1:0]          s_axil_rresp_o;
   logic                s_axil_rvalid_o;
   logic                s_axil_rready_i;
   logic                boot_o;
   logic                cpu_reset_o;

   // reference state
   logic [DATA_W-1:0]   sram_m [2**SRAM_ADDR_W];
   logic                boot_m;
   int                  soft_m;

   int seed;
   int errors;
   int n_checks;
   int cycles;
   int pulse_len;
   int last_pulse_len;
   int n_pulses;

   soc_fabric_top #(
      .ADDR_W     (ADDR_W),
      .DATA_W     (DATA_W),
      .SRAM_ADDR_W(SRAM_ADDR_W),
      .RST_CYCLES (RST_CYCLES)
   ) soc_fabric_top_i (
      .*
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   // run limit
   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the fabric stopped responding", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   // length of each cpu_reset_o pulse in low-phase samples
   always @(negedge clk_i) begin
      if (cpu_reset_o) begin
         pulse_len <= pulse_len + 1;
      end else if (pulse_len != 0) begin
         last_pulse_len <= pulse_len;
         n_pulses       <= n_pulses + 1;
         pulse_len      <= 0;
      end
   end

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         errors++;
         $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      n_checks++;
      assert (cond) else begin
         errors++;
         $display("** Error at time %0t: %s", $time, what);
      end
   endtask

   // byte strobes update SRAM words, CTRL writes update the boot state
   function automatic void update_model(input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] data,
                                        input logic [DATA_W/8-1:0] strb);
      if (!addr[ADDR_W-1]) begin
         for (int b = 0; b < DATA_W/8; b++) begin
            if (strb[b]) sram_m[addr[SRAM_ADDR_W+1:2]][8*b +: 8] = data[8*b +: 8];
         end
      end else if (int'(addr[ADDR_W-2:2]) == CTRL_OFS && strb[0]) begin
         boot_m = data[0];
         if (data[1]) soft_m++;
      end
   endfunction

   task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [DATA_W/8-1:0] strb);
      int lat;
      int delay;
      @(negedge clk_i);
      check_true(!s_axil_bvalid_o && !s_axil_rvalid_o, "response pending before a new write");
      s_axil_awaddr_i  = addr;
      s_axil_wdata_i   = data;
      s_axil_wstrb_i   = strb;
      s_axil_awvalid_i = 1'b1;
      s_axil_wvalid_i  = 1'b1;
      // ready settles in the low phase before the transfer edge
      #(CLK_PERIOD/4);
      while (!(s_axil_awready_o && s_axil_wready_o)) begin
         @(negedge clk_i);
         #(CLK_PERIOD/4);
      end
      @(negedge clk_i);
      check_true(!s_axil_awready_o && !s_axil_wready_o,
                 "write accepted again while the first one is in flight");
      s_axil_awvalid_i = 1'b0;
      s_axil_wvalid_i  = 1'b0;
      lat = 0;
      while (!s_axil_bvalid_o) begin
         @(negedge clk_i);
         lat++;
      end
      check_equal("write response latency", 32'(lat), 32'd2);
      check_equal("s_axil_bresp_o", 32'(s_axil_bresp_o), 32'd0);
      check_true(!s_axil_rvalid_o, "read response seen during a write");
      delay = $random(seed) & 3;
      repeat (delay) @(negedge clk_i);
      check_true(s_axil_bvalid_o, "write response dropped before bready");
      s_axil_bready_i = 1'b1;
      @(negedge clk_i);
      s_axil_bready_i = 1'b0;
      check_true(!s_axil_bvalid_o, "write response repeated after its handshake");
      update_model(addr, data, strb);
      check_equal("boot_o", 32'(boot_o), 32'(boot_m));
   endtask

   task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      int lat;
      int delay;
      @(negedge clk_i);
      check_true(!s_axil_bvalid_o && !s_axil_rvalid_o, "response pending before a new read");
      s_axil_araddr_i  = addr;
      s_axil_arvalid_i = 1'b1;
      #(CLK_PERIOD/4);
      while (!s_axil_arready_o) begin
         @(negedge clk_i);
         #(CLK_PERIOD/4);
      end
      @(negedge clk_i);
      check_true(!s_axil_arready_o, "read accepted again while the first one is in flight");
      s_axil_arvalid_i = 1'b0;
      lat = 0;
      while (!s_axil_rvalid_o) begin
         @(negedge clk_i);
         lat++;
      end
      check_equal("read response latency", 32'(lat), 32'd2);
      check_equal("s_axil_rresp_o", 32'(s_axil_rresp_o), 32'd0);
      check_true(!s_axil_bvalid_o, "write response seen during a read");
      data  = s_axil_rdata_o;
      delay = $random(seed) & 3;
      repeat (delay) @(negedge clk_i);
      check_true(s_axil_rvalid_o, "read response dropped before rready");
      // data must hold under back-pressure
      check_equal("s_axil_rdata_o", s_axil_rdata_o, data);
      s_axil_rready_i = 1'b1;
      @(negedge clk_i);
      s_axil_rready_i = 1'b0;
      check_true(!s_axil_rvalid_o, "read response repeated after its handshake");
   endtask

   initial begin
      step_t             s;
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] exp;
      int                n;
      seed             = 90;
      errors           = 0;
      n_checks         = 0;
      boot_m           = 1'b1;
      soft_m           = 0;
      arst_n_i         = 1'b0;
      s_axil_awaddr_i  = '0;
      s_axil_awvalid_i = 1'b0;
      s_axil_wdata_i   = '0;
      s_axil_wstrb_i   = '0;
      s_axil_wvalid_i  = 1'b0;
      s_axil_bready_i  = 1'b0;
      s_axil_araddr_i  = '0;
      s_axil_arvalid_i = 1'b0;
      s_axil_rready_i  = 1'b0;
      repeat (8) @(negedge clk_i);
      arst_n_i = 1'b1;

      // the release cycle counts as the first power-on pulse cycle
      n = 0;
      while (cpu_reset_o) begin
         n++;
         @(negedge clk_i);
      end
      check_equal("cpu_reset_o cycles after release", 32'(n), 32'(RST_CYCLES));
      check_equal("boot_o", 32'(boot_o), 32'd1);

      for (int i = 0; i < N_STEPS; i++) begin
         s = STEPS[i];
         case (s.op)
            OP_WR: axi_write(s.addr, s.wdata, s.wstrb);
            OP_RD: begin
               axi_read(s.addr, rd);
               exp = s.addr[ADDR_W-1] ? s.exp : sram_m[s.addr[SRAM_ADDR_W+1:2]];
               check_equal("s_axil_rdata_o", rd, exp);
            end
            default: begin
               // wait until the soft pulse has ended
               while (n_pulses != soft_m + 1) @(negedge clk_i);
               check_equal("cpu_reset_o pulse cycles", 32'(last_pulse_len),
                           32'(RST_CYCLES));
            end
         endcase
      end

      $display("%0d checks, %0d errors", n_checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/axil_iob_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_iob_bridge
   import soc_pkg::*;
#(
   parameter int ADDR_W = soc_pkg::ADDR_W,
   parameter int DATA_W = soc_pkg::DATA_W
) (
   input  wire                  clk_i,
   input  wire                  arst_n_i,

   input  wire [ADDR_W-1:0]     s_axil_awaddr_i,
   input  wire                  s_axil_awvalid_i,
   output logic                 s_axil_awready_o,
   input  wire [DATA_W-1:0]     s_axil_wdata_i,
   input  wire [DATA_W/8-1:0]   s_axil_wstrb_i,
   input  wire                  s_axil_wvalid_i,
   output logic                 s_axil_wready_o,
   output logic [1:0]           s_axil_bresp_o,
   output logic                 s_axil_bvalid_o,
   input  wire                  s_axil_bready_i,
   input  wire [ADDR_W-1:0]     s_axil_araddr_i,
   input  wire                  s_axil_arvalid_i,
   output logic                 s_axil_arready_o,
   output logic [DATA_W-1:0]    s_axil_rdata_o,
   output logic [1:0]           s_axil_rresp_o,
   output logic                 s_axil_rvalid_o,
   input  wire                  s_axil_rready_i,

   output iob_req_t             iob_req_o,
   input  wire iob_resp_t       iob_resp_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_RESP
   } state_t;

   state_t              state_q;
   logic                is_wr_q;
   logic [ADDR_W-1:0]   addr_q;
   logic [DATA_W-1:0]   wdata_q;
   logic [DATA_W/8-1:0] wstrb_q;
   logic [DATA_W-1:0]   rdata_q;
   logic                wr_hs;
   logic                rd_hs;

   // AW and W only together, write wins over a read offered in the same cycle
   assign wr_hs = (state_q == ST_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
   assign rd_hs = (state_q == ST_IDLE) && s_axil_arvalid_i &&
                  !(s_axil_awvalid_i && s_axil_wvalid_i);

   assign s_axil_awready_o = wr_hs;
   assign s_axil_wready_o  = wr_hs;
   assign s_axil_arready_o = rd_hs;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
         is_wr_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (wr_hs) begin
                  state_q <= ST_ISSUE;
                  is_wr_q <= 1'b1;
               end else if (rd_hs) begin
                  state_q <= ST_ISSUE;
                  is_wr_q <= 1'b0;
               end
            end
            ST_ISSUE: begin
               if (iob_resp_i.ready) state_q <= ST_WAIT;
            end
            // read data shows up one cycle after the request
            ST_WAIT: begin
               if (is_wr_q || iob_resp_i.rvalid) state_q <= ST_RESP;
            end
            default: begin
               if (is_wr_q ? s_axil_bready_i : s_axil_rready_i) state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // transaction payload
   always_ff @(posedge clk_i) begin
      if (wr_hs) begin
         addr_q  <= s_axil_awaddr_i;
         wdata_q <= s_axil_wdata_i;
         wstrb_q <= s_axil_wstrb_i;
      end else if (rd_hs) begin
         addr_q  <= s_axil_araddr_i;
      end
      if (state_q == ST_WAIT && iob_resp_i.rvalid) rdata_q <= iob_resp_i.rdata;
   end

   // one native request cycle, strobes zero for reads
   always_comb begin
      iob_req_o.avalid = (state_q == ST_ISSUE);
      iob_req_o.addr   = addr_q;
      iob_req_o.wdata  = wdata_q;
      iob_req_o.wstrb  = is_wr_q ? wstrb_q : '0;
   end

   assign s_axil_bvalid_o = (state_q == ST_RESP) && is_wr_q;
   assign s_axil_rvalid_o = (state_q == ST_RESP) && !is_wr_q;
   assign s_axil_rdata_o  = rdata_q;
   // always OKAY
   assign s_axil_bresp_o  = 2'b00;
   assign s_axil_rresp_o  = 2'b00;

endmodule

`default_nettype wire

/* source/iob_split.sv */
`timescale 1ns/1ps
`default_nettype none

module iob_split
   import soc_pkg::*;
#(
   parameter int N_SLAVES = 2,
   parameter int P_SLAVES = 11
) (
   input  wire                             clk_i,
   input  wire                             arst_n_i,

   // master side
   input  wire iob_req_t                   m_req_i,
   output iob_resp_t                       m_resp_o,

   // slave side
   output iob_req_t  [N_SLAVES-1:0]        s_req_o,
   input  wire iob_resp_t [N_SLAVES-1:0]   s_resp_i
);

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [SEL_W-1:0] sel;
   logic [SEL_W-1:0] rsel_q;
   logic             rd_req;

   // slave index sits at the top of the decoded field
   assign sel    = m_req_i.addr[P_SLAVES -: SEL_W];
   assign rd_req = m_req_i.avalid && (m_req_i.wstrb == '0);

   // requests fan out, avalid only to the selected slave
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_req_o[i]        = m_req_i;
         s_req_o[i].avalid = m_req_i.avalid && (sel == SEL_W'(i));
      end
   end

   // remember who owes us read data next cycle
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsel_q <= '0;
      end else if (rd_req) begin
         rsel_q <= sel;
      end
   end

   // response steering
   always_comb begin
      m_resp_o.rdata  = s_resp_i[rsel_q].rdata;
      m_resp_o.rvalid = s_resp_i[rsel_q].rvalid;
      m_resp_o.ready  = s_resp_i[sel].ready;
   end

endmodule

`default_nettype wire

/* source/iob_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module iob_sram
   import soc_pkg::*;
#(
   parameter int SRAM_ADDR_W = 8
) (
   input  wire            clk_i,
   input  wire            arst_n_i,
   input  wire iob_req_t  req_i,
   output iob_resp_t      resp_o
);

   localparam int N_WORDS = 2 ** SRAM_ADDR_W;
   localparam int N_BYTES = DATA_W / 8;

   logic [DATA_W-1:0]      mem [N_WORDS];
   logic [SRAM_ADDR_W-1:0] word_addr;
   logic [DATA_W-1:0]      rdata_q;
   logic                   rvalid_q;
   logic                   rd_req;

   // byte address to word index
   assign word_addr = req_i.addr[SRAM_ADDR_W+1:2];
   assign rd_req    = req_i.avalid && (req_i.wstrb == '0);

   // per-lane writes under the strobes
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < N_BYTES; b++) begin
         if (req_i.avalid && req_i.wstrb[b]) begin
            mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
         end
      end
      if (rd_req) rdata_q <= mem[word_addr];
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_req;
      end
   end

   // always ready, data one cycle later
   assign resp_o.ready  = 1'b1;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

/* source/soc_boot_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_boot_ctrl
   import soc_pkg::*;
#(
   parameter int RST_CYCLES = 4
) (
   input  wire            clk_i,
   input  wire            arst_n_i,
   input  wire iob_req_t  req_i,
   output iob_resp_t      resp_o,
   output logic           boot_o,
   output logic           cpu_reset_o
);

   localparam int CNT_W = $clog2(RST_CYCLES + 1);
   localparam int OFS_W = ADDR_W - 3;

   logic [CNT_W-1:0]  rst_cnt_q;
   logic              soft_q;
   logic              boot_q;
   logic [7:0]        nrst_q;
   logic [OFS_W-1:0]  ofs;
   logic              ctrl_wr;
   logic              rd_req;
   logic [DATA_W-1:0] rd_val;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;

   // word offset below the slave select bit
   assign ofs     = req_i.addr[ADDR_W-2:2];
   assign ctrl_wr = req_i.avalid && req_i.wstrb[0] && (ofs == OFS_W'(CTRL_OFS));
   assign rd_req  = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         // power-on pulse starts full
         rst_cnt_q <= CNT_W'(RST_CYCLES);
         soft_q    <= 1'b0;
         boot_q    <= 1'b1;
         nrst_q    <= '0;
         rvalid_q  <= 1'b0;
      end else begin
         rvalid_q <= rd_req;
         if (ctrl_wr) boot_q <= req_i.wdata[0];
         if (ctrl_wr && req_i.wdata[1]) begin
            rst_cnt_q <= CNT_W'(RST_CYCLES);
            soft_q    <= 1'b1;
         end else if (rst_cnt_q != '0) begin
            rst_cnt_q <= rst_cnt_q - 1'b1;
            // last cycle of a soft pulse
            if (rst_cnt_q == CNT_W'(1) && soft_q) begin
               nrst_q <= nrst_q + 1'b1;
               soft_q <= 1'b0;
            end
         end
      end
   end

   // register read mux, unmapped offsets give zero
   always_comb begin
      rd_val = '0;
      if (ofs == OFS_W'(CTRL_OFS)) begin
         rd_val[0] = boot_q;
      end else if (ofs == OFS_W'(STATUS_OFS)) begin
         rd_val[0]    = boot_q;
         rd_val[1]    = cpu_reset_o;
         rd_val[15:8] = nrst_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_req) rdata_q <= rd_val;
   end

   assign boot_o        = boot_q;
   assign cpu_reset_o   = (rst_cnt_q != '0);
   assign resp_o.ready  = 1'b1;
   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

/* source/soc_fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_top
   import soc_pkg::*;
#(
   parameter int ADDR_W      = soc_pkg::ADDR_W,
   parameter int DATA_W      = soc_pkg::DATA_W,
   parameter int SRAM_ADDR_W = 8,
   parameter int RST_CYCLES  = 4
) (
   input  wire                  clk_i,
   input  wire                  arst_n_i,

   input  wire [ADDR_W-1:0]     s_axil_awaddr_i,
   input  wire                  s_axil_awvalid_i,
   output logic                 s_axil_awready_o,
   input  wire [DATA_W-1:0]     s_axil_wdata_i,
   input  wire [DATA_W/8-1:0]   s_axil_wstrb_i,
   input  wire                  s_axil_wvalid_i,
   output logic                 s_axil_wready_o,
   output logic [1:0]           s_axil_bresp_o,
   output logic                 s_axil_bvalid_o,
   input  wire                  s_axil_bready_i,
   input  wire [ADDR_W-1:0]     s_axil_araddr_i,
   input  wire                  s_axil_arvalid_i,
   output logic                 s_axil_arready_o,
   output logic [DATA_W-1:0]    s_axil_rdata_o,
   output logic [1:0]           s_axil_rresp_o,
   output logic                 s_axil_rvalid_o,
   input  wire                  s_axil_rready_i,

   output logic                 boot_o,
   output logic                 cpu_reset_o
);

   iob_req_t        host_req;
   iob_resp_t       host_resp;
   // slave 0 is the SRAM, slave 1 boot control
   iob_req_t  [1:0] slv_req;
   iob_resp_t [1:0] slv_resp;

   axil_iob_bridge #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) bridge_i (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .s_axil_awaddr_i (s_axil_awaddr_i),
      .s_axil_awvalid_i(s_axil_awvalid_i),
      .s_axil_awready_o(s_axil_awready_o),
      .s_axil_wdata_i  (s_axil_wdata_i),
      .s_axil_wstrb_i  (s_axil_wstrb_i),
      .s_axil_wvalid_i (s_axil_wvalid_i),
      .s_axil_wready_o (s_axil_wready_o),
      .s_axil_bresp_o  (s_axil_bresp_o),
      .s_axil_bvalid_o (s_axil_bvalid_o),
      .s_axil_bready_i (s_axil_bready_i),
      .s_axil_araddr_i (s_axil_araddr_i),
      .s_axil_arvalid_i(s_axil_arvalid_i),
      .s_axil_arready_o(s_axil_arready_o),
      .s_axil_rdata_o  (s_axil_rdata_o),
      .s_axil_rresp_o  (s_axil_rresp_o),
      .s_axil_rvalid_o (s_axil_rvalid_o),
      .s_axil_rready_i (s_axil_rready_i),
      .iob_req_o       (host_req),
      .iob_resp_i      (host_resp)
   );

   // top address bit picks the slave
   iob_split #(
      .N_SLAVES(2),
      .P_SLAVES(ADDR_W - 1)
   ) split_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .m_req_i (host_req),
      .m_resp_o(host_resp),
      .s_req_o (slv_req),
      .s_resp_i(slv_resp)
   );

   iob_sram #(
      .SRAM_ADDR_W(SRAM_ADDR_W)
   ) sram_i (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (slv_req[0]),
      .resp_o  (slv_resp[0])
   );

   soc_boot_ctrl #(
      .RST_CYCLES(RST_CYCLES)
   ) boot_ctrl_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_i      (slv_req[1]),
      .resp_o     (slv_resp[1]),
      .boot_o     (boot_o),
      .cpu_reset_o(cpu_reset_o)
   );

endmodule

`default_nettype wire

/* source/soc_pkg.sv */
`default_nettype none

package soc_pkg;

   // host byte address and data widths
   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;

   // native memory bus request
   // a nonzero wstrb marks a write, all zero marks a read
   typedef struct packed {
      logic                avalid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
   } iob_req_t;

   // native memory bus response
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_resp_t;

   // boot control register word offsets
   localparam int CTRL_OFS   = 0;
   localparam int STATUS_OFS = 1;

endpackage

`default_nettype wire
